//--- hw/adv_timer_defines.svh
// Shared sizes, register map and CTRL field positions of the APB timer subsystem
// Timer n owns the 16-byte window at byte 16*n; offsets below are inside that window
`ifndef ADV_TIMER_DEFINES_SVH
`define ADV_TIMER_DEFINES_SVH

`define ADV_TIMER_NUM           4      // Number of timer blocks
`define ADV_TIMER_CNT_W         16     // Counter, period and compare width
`define ADV_TIMER_PRESC_W       8      // Prescaler width

// Per-timer window offsets, low nibble of paddr
`define ADV_TIMER_OFS_CTRL      4'h0
`define ADV_TIMER_OFS_PERIOD    4'h4
`define ADV_TIMER_OFS_COMPARE   4'h8
`define ADV_TIMER_OFS_COUNT     4'hC   // Read only

// Global registers above the timer windows
`define ADV_TIMER_OFS_STATUS    8'h40  // W1C, cmp bits low, ovf bits high
`define ADV_TIMER_OFS_MASK      8'h44

// CTRL fields
`define ADV_TIMER_CTRL_EN       0      // Enable
`define ADV_TIMER_CTRL_SRC      1      // 1 selects low_speed_clk
`define ADV_TIMER_CTRL_PRESC_LO 8
`define ADV_TIMER_CTRL_PRESC_HI 15

`endif

//--- hw/adv_timer_pkg.sv
// Bus and timer types of the APB timer subsystem
// APB address is 8 bits wide, data 32 bits; no pprot or pstrb
`default_nettype none

`include "adv_timer_defines.svh"

package adv_timer_pkg;

   // APB master to slave
   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   // APB slave to master
   typedef struct packed {
      logic        pready;                        // Tied high, zero wait states
      logic [31:0] prdata;
      logic        pslverr;
   } apb_rsp_t;

   // Programmed setup of one timer
   typedef struct packed {
      logic                            enable;
      logic                            src_lsclk; // Tick on low_speed_clk edges
      logic [`ADV_TIMER_PRESC_W-1:0]   presc;     // Divide ticks by presc+1
      logic [`ADV_TIMER_CNT_W-1:0]     period;    // Last count before wrap
      logic [`ADV_TIMER_CNT_W-1:0]     compare;
   } timer_cfg_t;

   // One-cycle event pulses, one bit per timer
   typedef struct packed {
      logic [`ADV_TIMER_NUM-1:0] cmp;
      logic [`ADV_TIMER_NUM-1:0] ovf;
   } timer_evt_t;

endpackage : adv_timer_pkg

`default_nettype wire

//--- hw/apb_timer_regs.sv
// APB register file for the timer subsystem, zero wait states, pready always high
// Unmapped or unaligned addresses and COUNT writes answer pslverr and change nothing
// prdata is 0 outside a read access phase
`timescale 1ns/1ps
`default_nettype none

`include "adv_timer_defines.svh"

module apb_timer_regs (
   input  wire                          HCLK,
   input  wire                          rst_n,
   input  adv_timer_pkg::apb_req_t      apb_req,
   output adv_timer_pkg::apb_rsp_t      apb_rsp,
   output adv_timer_pkg::timer_cfg_t    cfg [`ADV_TIMER_NUM],
   input  wire [`ADV_TIMER_CNT_W-1:0]   count [`ADV_TIMER_NUM],
   input  wire [2*`ADV_TIMER_NUM-1:0]   status,
   output logic [`ADV_TIMER_NUM-1:0]    mask,
   output logic [2*`ADV_TIMER_NUM-1:0]  status_clr
);

   localparam int          IDX_W    = $clog2(`ADV_TIMER_NUM);
   localparam int unsigned TMR_SPAN = `ADV_TIMER_NUM * 16;     // Bytes taken by timer windows

   logic             access;       // APB access phase
   logic             wr;
   logic             rd;
   logic             tmr_hit;      // Address inside a timer window
   logic [IDX_W-1:0] tmr_idx;
   logic [3:0]       reg_ofs;      // Offset inside the window
   logic             sel_ctrl;
   logic             sel_period;
   logic             sel_compare;
   logic             sel_count;
   logic             sel_status;
   logic             sel_mask;
   logic             addr_ok;
   logic             err;
   logic             wr_ok;
   logic [31:0]      rdata;

   assign access  = apb_req.psel & apb_req.penable;
   assign wr      = access & apb_req.pwrite;
   assign rd      = access & ~apb_req.pwrite;

   assign tmr_hit = (32'(apb_req.paddr) < TMR_SPAN);
   assign tmr_idx = apb_req.paddr[4 +: IDX_W];
   assign reg_ofs = apb_req.paddr[3:0];

   assign sel_ctrl    = tmr_hit & (reg_ofs == `ADV_TIMER_OFS_CTRL);
   assign sel_period  = tmr_hit & (reg_ofs == `ADV_TIMER_OFS_PERIOD);
   assign sel_compare = tmr_hit & (reg_ofs == `ADV_TIMER_OFS_COMPARE);
   assign sel_count   = tmr_hit & (reg_ofs == `ADV_TIMER_OFS_COUNT);
   assign sel_status  = (apb_req.paddr == `ADV_TIMER_OFS_STATUS);
   assign sel_mask    = (apb_req.paddr == `ADV_TIMER_OFS_MASK);

   assign addr_ok = sel_ctrl | sel_period | sel_compare | sel_count | sel_status | sel_mask;
   assign err     = access & (~addr_ok | (apb_req.pwrite & sel_count)); // COUNT is read only
   assign wr_ok   = wr & ~err;

   // Timer configuration and interrupt mask
   always_ff @(posedge HCLK or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `ADV_TIMER_NUM; i++) begin
            cfg[i] <= '0;
         end
         mask <= '0;
      end else if (wr_ok) begin
         for (int i = 0; i < `ADV_TIMER_NUM; i++) begin
            if (tmr_idx == IDX_W'(i)) begin
               if (sel_ctrl) begin
                  cfg[i].enable    <= apb_req.pwdata[`ADV_TIMER_CTRL_EN];
                  cfg[i].src_lsclk <= apb_req.pwdata[`ADV_TIMER_CTRL_SRC];
                  cfg[i].presc     <=
                     apb_req.pwdata[`ADV_TIMER_CTRL_PRESC_HI:`ADV_TIMER_CTRL_PRESC_LO];
               end
               if (sel_period) begin
                  cfg[i].period <= apb_req.pwdata[`ADV_TIMER_CNT_W-1:0];
               end
               if (sel_compare) begin
                  cfg[i].compare <= apb_req.pwdata[`ADV_TIMER_CNT_W-1:0];
               end
            end
         end
         if (sel_mask) begin
            mask <= apb_req.pwdata[`ADV_TIMER_NUM-1:0];
         end
      end
   end

   // W1C pulse, lasts the access cycle only
   assign status_clr = (wr_ok & sel_status) ? apb_req.pwdata[2*`ADV_TIMER_NUM-1:0] : '0;

   // Read mux
   always_comb begin
      rdata = '0;
      if (rd & addr_ok) begin
         if (sel_ctrl) begin
            rdata[`ADV_TIMER_CTRL_EN]  = cfg[tmr_idx].enable;
            rdata[`ADV_TIMER_CTRL_SRC] = cfg[tmr_idx].src_lsclk;
            rdata[`ADV_TIMER_CTRL_PRESC_HI:`ADV_TIMER_CTRL_PRESC_LO] = cfg[tmr_idx].presc;
         end else if (sel_period) begin
            rdata = 32'(cfg[tmr_idx].period);
         end else if (sel_compare) begin
            rdata = 32'(cfg[tmr_idx].compare);
         end else if (sel_count) begin
            rdata = 32'(count[tmr_idx]);            // Live counter value
         end else if (sel_status) begin
            rdata = 32'(status);
         end else begin
            rdata = 32'(mask);
         end
      end
   end

   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.prdata  = rdata;
   assign apb_rsp.pslverr = err;

endmodule : apb_timer_regs

`default_nettype wire

//--- hw/adv_timer_block.sv
// One timer channel: tick select, prescaler, wrapping up counter, compare and PWM
// low_speed_clk is sampled in HCLK, so it must stay well below HCLK/2
// Events are one-cycle pulses aligned with the count they describe
`timescale 1ns/1ps
`default_nettype none

`include "adv_timer_defines.svh"

module adv_timer_block (
   input  wire                           HCLK,
   input  wire                           rst_n,
   input  wire                           low_speed_clk,
   input  adv_timer_pkg::timer_cfg_t     cfg,
   output logic [`ADV_TIMER_CNT_W-1:0]   count,
   output logic                          cmp_evt,
   output logic                          ovf_evt,
   output logic                          pwm
);

   logic [1:0]                    ls_sync;    // Two-flop synchronizer
   logic                          ls_prev;    // Last synchronized level
   logic                          ls_rise;
   logic                          tick;
   logic [`ADV_TIMER_PRESC_W-1:0] presc_cnt;
   logic                          advance;    // Counter steps this cycle
   logic                          wrap;
   logic [`ADV_TIMER_CNT_W-1:0]   count_d;

   // Bring low_speed_clk into HCLK and find its rising edges
   always_ff @(posedge HCLK or negedge rst_n) begin
      if (!rst_n) begin
         ls_sync <= '0;
         ls_prev <= 1'b0;
      end else begin
         ls_sync <= {ls_sync[0], low_speed_clk};
         ls_prev <= ls_sync[1];
      end
   end

   assign ls_rise = ls_sync[1] & ~ls_prev;
   assign tick    = cfg.src_lsclk ? ls_rise : 1'b1; // Every HCLK cycle on the fast source

   // >= keeps a lowered presc from running the full prescaler range
   assign advance = cfg.enable & tick & (presc_cnt >= cfg.presc);

   always_ff @(posedge HCLK or negedge rst_n) begin
      if (!rst_n) begin
         presc_cnt <= '0;
      end else if (!cfg.enable) begin
         presc_cnt <= '0;                           // Cleared while disabled
      end else if (tick) begin
         presc_cnt <= advance ? '0 : presc_cnt + 1'b1;
      end
   end

   // Wrap at period or past it, in case period was lowered under the count
   assign wrap = (count >= cfg.period);

   always_comb begin
      count_d = count;                              // Hold when disabled or idle
      if (advance) begin
         count_d = wrap ? '0 : count + 1'b1;
      end
   end

   always_ff @(posedge HCLK or negedge rst_n) begin
      if (!rst_n) begin
         count   <= '0;
         cmp_evt <= 1'b0;
         ovf_evt <= 1'b0;
         pwm     <= 1'b0;
      end else begin
         count   <= count_d;
         cmp_evt <= advance & (count_d == cfg.compare);
         ovf_evt <= advance & wrap;
         pwm     <= cfg.enable & (count_d < cfg.compare); // Follows the new count
      end
   end

endmodule : adv_timer_block

`default_nettype wire

//--- hw/timer_event_irq.sv
// Sticky compare/overflow status with W1C clear and masked per-timer interrupts
// Status bit layout: cmp of timer n at bit n, ovf of timer n at bit NUM+n
// A new event beats a clear of the same bit in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "adv_timer_defines.svh"

module timer_event_irq (
   input  wire                           HCLK,
   input  wire                           rst_n,
   input  adv_timer_pkg::timer_evt_t     evt,
   input  wire [2*`ADV_TIMER_NUM-1:0]    status_clr,
   input  wire [`ADV_TIMER_NUM-1:0]      mask,
   output logic [2*`ADV_TIMER_NUM-1:0]   status,
   output logic [`ADV_TIMER_NUM-1:0]     irq
);

   logic [2*`ADV_TIMER_NUM-1:0] evt_set;   // Event pulses in status layout
   logic [`ADV_TIMER_NUM-1:0]   cmp_stat;
   logic [`ADV_TIMER_NUM-1:0]   ovf_stat;

   assign evt_set = {evt.ovf, evt.cmp};

   always_ff @(posedge HCLK or negedge rst_n) begin
      if (!rst_n) begin
         status <= '0;
      end else begin
         status <= (status & ~status_clr) | evt_set; // Set wins over clear
      end
   end

   assign cmp_stat = status[`ADV_TIMER_NUM-1:0];
   assign ovf_stat = status[2*`ADV_TIMER_NUM-1:`ADV_TIMER_NUM];

   // Level interrupt, drops with the status clear or the mask
   assign irq = mask & (cmp_stat | ovf_stat);

endmodule : timer_event_irq

`default_nettype wire

//--- hw/apb_adv_timer_ss.sv
// APB timer subsystem top: register block, four timer blocks, event/IRQ unit
// All logic runs on HCLK; low_speed_clk is only sampled inside the timers
`timescale 1ns/1ps
`default_nettype none

`include "adv_timer_defines.svh"

module apb_adv_timer_ss (
   input  wire                          HCLK,
   input  wire                          rst_n,
   input  wire                          low_speed_clk,
   input  adv_timer_pkg::apb_req_t      apb_req,
   output adv_timer_pkg::apb_rsp_t      apb_rsp,
   output logic [`ADV_TIMER_NUM-1:0]    pwm,
   output logic [`ADV_TIMER_NUM-1:0]    irq
);

   import adv_timer_pkg::*;

   timer_cfg_t                    cfg [`ADV_TIMER_NUM];   // Per-timer setup
   logic [`ADV_TIMER_CNT_W-1:0]   count [`ADV_TIMER_NUM]; // Live counts for readback
   logic [`ADV_TIMER_NUM-1:0]     cmp_evt;
   logic [`ADV_TIMER_NUM-1:0]     ovf_evt;
   timer_evt_t                    evt;
   logic [2*`ADV_TIMER_NUM-1:0]   status;
   logic [2*`ADV_TIMER_NUM-1:0]   status_clr;
   logic [`ADV_TIMER_NUM-1:0]     mask;

   apb_timer_regs regs_i (
      .HCLK       (HCLK),
      .rst_n      (rst_n),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .cfg        (cfg),
      .count      (count),
      .status     (status),
      .mask       (mask),
      .status_clr (status_clr)
   );

   for (genvar i = 0; i < `ADV_TIMER_NUM; i++) begin : g_timer
      adv_timer_block timer_i (
         .HCLK          (HCLK),
         .rst_n         (rst_n),
         .low_speed_clk (low_speed_clk),
         .cfg           (cfg[i]),
         .count         (count[i]),
         .cmp_evt       (cmp_evt[i]),
         .ovf_evt       (ovf_evt[i]),
         .pwm           (pwm[i])
      );
   end

   assign evt.cmp = cmp_evt;                  // Gather event bits
   assign evt.ovf = ovf_evt;

   timer_event_irq evt_irq_i (
      .HCLK       (HCLK),
      .rst_n      (rst_n),
      .evt        (evt),
      .status_clr (status_clr),
      .mask       (mask),
      .status     (status),
      .irq        (irq)
   );

endmodule : apb_adv_timer_ss

`default_nettype wire

//--- test/tb_clk_gen.sv
// HCLK and rst_n source for the timer subsystem testbench
// Reset is released with a non-blocking update on a rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 5
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;                                 // Held low from time 0
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule : tb_clk_gen

`default_nettype wire

//--- test/apb_adv_timer_ss_chk.sv
// Concurrent checks on the APB response, irq masking and PWM level of the timer subsystem
// Bound into apb_adv_timer_ss; all checks are off while rst_n is low
`timescale 1ns/1ps
`default_nettype none

`include "adv_timer_defines.svh"

module apb_adv_timer_ss_chk (
   input logic                            hclk,
   input logic                            rst_n,
   input adv_timer_pkg::apb_req_t         apb_req,
   input adv_timer_pkg::apb_rsp_t         apb_rsp,
   input logic [`ADV_TIMER_NUM-1:0]       mask,
   input logic [`ADV_TIMER_NUM-1:0]       irq,
   input logic [`ADV_TIMER_NUM-1:0]       pwm,
   input adv_timer_pkg::timer_cfg_t       cfg [`ADV_TIMER_NUM],
   input logic [`ADV_TIMER_CNT_W-1:0]     count [`ADV_TIMER_NUM]
);

   int err_cnt = 0;                                 // Failed checks, polled by the testbench

   // Error response only in the access phase
   pslverr_in_access: assert property (@(posedge hclk) disable iff (!rst_n)
      apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
   else begin
      $error("pslverr outside an APB access phase");
      err_cnt = err_cnt + 1;
   end

   irq_needs_mask: assert property (@(posedge hclk) disable iff (!rst_n)
      (mask == '0) |-> (irq == '0))
   else begin
      $error("irq high while the mask is all zero");
      err_cnt = err_cnt + 1;
   end

   // pwm is registered, so compare must have held for a cycle
   for (genvar i = 0; i < `ADV_TIMER_NUM; i++) begin : g_pwm
      pwm_low_at_compare: assert property (@(posedge hclk) disable iff (!rst_n)
         ((count[i] >= cfg[i].compare) && $stable(cfg[i].compare)) |-> !pwm[i])
      else begin
         $error("pwm of timer %0d high with count at or above compare", i);
         err_cnt = err_cnt + 1;
      end
   end

endmodule : apb_adv_timer_ss_chk

`default_nettype wire

//--- test/apb_adv_timer_ss_tb.sv
// Testbench for the APB timer subsystem that exercises one timer at a time
// Status and irq expectations assume the timers not under test are stopped
`timescale 1ns/1ps
`default_nettype none

`include "adv_timer_defines.svh"

module apb_adv_timer_ss_tb;

   import adv_timer_pkg::*;

   localparam int CLK_NS       = 40;
   localparam int XFER_CYC     = 3;                // APB transfer incl. idle cycle
   localparam int COUNT_READS  = 200;
   localparam int LS_WAIT      = 300;              // Budget for six low_speed_clk rises
   localparam int EVT_READS    = 40;
   localparam int WATCHDOG_CYC = 5 + 40 * XFER_CYC + (COUNT_READS + 10) * XFER_CYC
                                 + LS_WAIT + 20 * XFER_CYC + (EVT_READS + 12) * XFER_CYC
                                 + 100 + 8 * XFER_CYC + 200;
   // cmp and ovf status bits of timer 2
   localparam logic [31:0] T2_EVT = (32'h1 << 2) | (32'h1 << (`ADV_TIMER_NUM + 2));

   logic                      hclk;
   logic                      rst_n;
   logic                      low_speed_clk;
   apb_req_t                  apb_req;
   apb_rsp_t                  apb_rsp;
   logic [`ADV_TIMER_NUM-1:0] pwm;
   logic [`ADV_TIMER_NUM-1:0] irq;
   logic                      ls_run = 1'b0;     // Lets low_speed_clk toggle
   int unsigned               ls_rises = 0;      // Rising edges driven so far
   int unsigned               ls_gap [32];       // Random level lengths in HCLK cycles

   tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(5)) clk_gen_i (.clk(hclk), .rst_n(rst_n));

   apb_adv_timer_ss dut_i (
      .HCLK          (hclk),
      .rst_n         (rst_n),
      .low_speed_clk (low_speed_clk),
      .apb_req       (apb_req),
      .apb_rsp       (apb_rsp),
      .pwm           (pwm),
      .irq           (irq)
   );

   bind apb_adv_timer_ss apb_adv_timer_ss_chk chk_i (
      .hclk    (HCLK),
      .rst_n   (rst_n),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .mask    (mask),
      .irq     (irq),
      .pwm     (pwm),
      .cfg     (cfg),
      .count   (count)
   );

   task automatic stop_on_failure(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp) else stop_on_failure($sformatf(
         "Mismatch at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp));
   endtask

   function automatic logic [7:0] tmr_addr(input int n, input logic [3:0] ofs);
      return {n[3:0], ofs};                         // 16-byte window per timer
   endfunction

   // Setup on one edge and access on the next with data sampled mid-cycle
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(posedge hclk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      @(posedge hclk);
      apb_req.penable <= 1'b1;
      @(negedge hclk);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      expect_eq(32'(apb_rsp.pready), 32'h1, "pready in access phase");
      @(posedge hclk);                              // Write lands on this edge
      apb_req <= '0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      logic        err;
      apb_xfer(1'b1, addr, data, unused, err);
      expect_eq(32'(err), 32'h0, $sformatf("pslverr of write to 0x%02h", addr));
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
      logic err;
      apb_xfer(1'b0, addr, 32'h0, data, err);
      expect_eq(32'(err), 32'h0, $sformatf("pslverr of read from 0x%02h", addr));
   endtask

   task automatic watch_pwm(input int n, input logic exp, input int cycles);
      repeat (cycles) begin
         @(negedge hclk);
         assert (pwm[n] === exp) else stop_on_failure($sformatf(
            "Mismatch at %0d ns: pwm[%0d] is %b, expected %b", $time, n, pwm[n], exp));
      end
   endtask

   // Slow irregular low_speed_clk that runs only while ls_run is set
   initial begin : lsclk_gen
      int unsigned idx;
      idx = 0;
      low_speed_clk = 1'b0;
      forever begin
         @(posedge hclk);
         if (ls_run) begin
            repeat (ls_gap[idx]) @(posedge hclk);
            idx = (idx + 1) % 32;
            if (ls_run) begin
               if (!low_speed_clk) ls_rises = ls_rises + 1;
               low_speed_clk <= ~low_speed_clk;
            end
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYC * CLK_NS);
      stop_on_failure($sformatf("Timeout: run did not finish in %0d cycles", WATCHDOG_CYC));
   end

   always @(negedge hclk) begin
      if (dut_i.chk_i.err_cnt != 0) stop_on_failure("A concurrent assertion in the checker failed");
   end

   initial begin : stimulus
      logic [31:0] val;
      logic [31:0] rd;
      logic [31:0] prev;
      logic [31:0] mask_val;
      logic [31:0] cnt_a;
      logic [31:0] cnt_b;
      logic [31:0] period;
      logic [31:0] presc;
      logic [31:0] bound;
      logic        err;
      logic        wrapped;
      int unsigned rises_start;

      apb_req = '0;
      void'($urandom(8787));
      for (int i = 0; i < 32; i++) ls_gap[i] = 4 + ($urandom % 7);
      @(posedge rst_n);

      // Register readback of the defined fields only
      for (int n = 0; n < `ADV_TIMER_NUM; n++) begin
         val = $urandom;
         val[0] = 1'b0;                             // Timers stay stopped
         reg_write(tmr_addr(n, `ADV_TIMER_OFS_CTRL), val);
         reg_read(tmr_addr(n, `ADV_TIMER_OFS_CTRL), rd);
         expect_eq(rd, val & 32'h0000_FF03, "CTRL readback");
         val = $urandom;
         reg_write(tmr_addr(n, `ADV_TIMER_OFS_PERIOD), val);
         reg_read(tmr_addr(n, `ADV_TIMER_OFS_PERIOD), rd);
         expect_eq(rd, val & 32'h0000_FFFF, "PERIOD readback");
         val = $urandom;
         reg_write(tmr_addr(n, `ADV_TIMER_OFS_COMPARE), val);
         reg_read(tmr_addr(n, `ADV_TIMER_OFS_COMPARE), rd);
         expect_eq(rd, val & 32'h0000_FFFF, "COMPARE readback");
      end
      mask_val = $urandom;
      reg_write(`ADV_TIMER_OFS_MASK, mask_val);
      reg_read(`ADV_TIMER_OFS_MASK, rd);
      expect_eq(rd, mask_val & 32'hF, "MASK readback");
      reg_read(tmr_addr(0, `ADV_TIMER_OFS_CTRL), prev);
      apb_xfer(1'b1, tmr_addr(0, `ADV_TIMER_OFS_COUNT), 32'h1234, rd, err);
      expect_eq(32'(err), 32'h1, "pslverr of COUNT write");
      apb_xfer(1'b0, 8'h48, 32'h0, rd, err);
      expect_eq(32'(err), 32'h1, "pslverr of unmapped read");
      apb_xfer(1'b1, 8'h80, 32'hFFFF_FFFF, rd, err);
      expect_eq(32'(err), 32'h1, "pslverr of unmapped write");
      reg_read(tmr_addr(0, `ADV_TIMER_OFS_CTRL), rd);
      expect_eq(rd, prev, "CTRL after bad accesses");
      reg_read(tmr_addr(0, `ADV_TIMER_OFS_COUNT), rd);
      expect_eq(rd, 32'h0, "COUNT after write attempt");
      reg_read(`ADV_TIMER_OFS_MASK, rd);
      expect_eq(rd, mask_val & 32'hF, "MASK after bad accesses");
      reg_write(`ADV_TIMER_OFS_MASK, 32'h0);

      // HCLK counting on timer 0
      period = 32'd20 + ($urandom % 40);
      presc  = $urandom % 4;
      reg_write(tmr_addr(0, `ADV_TIMER_OFS_PERIOD), period);
      reg_write(tmr_addr(0, `ADV_TIMER_OFS_COMPARE), period >> 1);
      reg_write(tmr_addr(0, `ADV_TIMER_OFS_CTRL), (presc << 8) | 32'h1);
      prev = 32'h0;
      wrapped = 1'b0;
      for (int i = 0; i < COUNT_READS && !wrapped; i++) begin
         reg_read(tmr_addr(0, `ADV_TIMER_OFS_COUNT), rd);
         assert (rd <= period) else stop_on_failure($sformatf(
            "Mismatch at %0d ns: count %0d above period %0d", $time, rd, period));
         wrapped = (rd < prev);
         prev = rd;
      end
      assert (wrapped) else stop_on_failure("Timer 0 count did not wrap within the read budget");
      reg_write(tmr_addr(0, `ADV_TIMER_OFS_CTRL), presc << 8);
      reg_read(tmr_addr(0, `ADV_TIMER_OFS_COUNT), cnt_a);
      reg_read(tmr_addr(0, `ADV_TIMER_OFS_COUNT), cnt_b);
      expect_eq(cnt_b, cnt_a, "count of disabled timer 0");

      // Low-speed source on timer 1
      presc = $urandom % 3;
      reg_write(tmr_addr(1, `ADV_TIMER_OFS_PERIOD), 32'hFFFF);
      reg_write(tmr_addr(1, `ADV_TIMER_OFS_CTRL), (presc << 8) | 32'h3);
      reg_read(tmr_addr(1, `ADV_TIMER_OFS_COUNT), cnt_a);
      repeat (20) @(posedge hclk);
      reg_read(tmr_addr(1, `ADV_TIMER_OFS_COUNT), cnt_b);
      expect_eq(cnt_b, cnt_a, "count with low_speed_clk held");
      rises_start = ls_rises;
      ls_run = 1'b1;
      for (int i = 0; i < LS_WAIT && ls_rises - rises_start < 6; i++) @(posedge hclk);
      ls_run = 1'b0;
      repeat (5) @(posedge hclk);                   // Synchronizer catches the last edge
      assert (ls_rises - rises_start >= 6)
         else stop_on_failure("low_speed_clk gave too few rising edges in time");
      bound = (ls_rises - rises_start + presc) / (presc + 32'd1);
      reg_read(tmr_addr(1, `ADV_TIMER_OFS_COUNT), rd);
      assert ((rd != cnt_b) && (rd - cnt_b <= bound)) else stop_on_failure($sformatf(
         "Mismatch at %0d ns: low-speed advance %0d, limit %0d", $time, rd - cnt_b, bound));
      reg_write(tmr_addr(1, `ADV_TIMER_OFS_CTRL), 32'h0);

      // Events and interrupts on timer 2
      reg_write(`ADV_TIMER_OFS_STATUS, 32'hFF);
      reg_write(tmr_addr(2, `ADV_TIMER_OFS_PERIOD), 32'd9);
      reg_write(tmr_addr(2, `ADV_TIMER_OFS_COMPARE), 32'd4);
      reg_write(tmr_addr(2, `ADV_TIMER_OFS_CTRL), 32'h1);
      rd = 32'h0;
      for (int i = 0; i < EVT_READS && !rd[`ADV_TIMER_NUM + 2]; i++) begin
         reg_read(`ADV_TIMER_OFS_STATUS, rd);
      end
      expect_eq(rd & T2_EVT, T2_EVT, "STATUS of timer 2 after wrap");
      @(negedge hclk);
      expect_eq(32'(irq), 32'h0, "irq with mask clear");
      reg_write(tmr_addr(2, `ADV_TIMER_OFS_CTRL), 32'h0);
      reg_write(`ADV_TIMER_OFS_MASK, 32'h4);
      @(negedge hclk);
      expect_eq(32'(irq), 32'h4, "irq with timer 2 unmasked");
      reg_write(`ADV_TIMER_OFS_STATUS, T2_EVT);
      @(negedge hclk);
      expect_eq(32'(irq), 32'h0, "irq after STATUS clear");
      reg_read(`ADV_TIMER_OFS_STATUS, rd);
      expect_eq(rd, 32'h0, "STATUS after clear");

      // PWM levels on timer 3
      reg_write(tmr_addr(3, `ADV_TIMER_OFS_PERIOD), 32'd15);
      reg_write(tmr_addr(3, `ADV_TIMER_OFS_COMPARE), 32'd0);
      reg_write(tmr_addr(3, `ADV_TIMER_OFS_CTRL), 32'h1);
      watch_pwm(3, 1'b0, 40);
      reg_write(tmr_addr(3, `ADV_TIMER_OFS_CTRL), 32'h0);
      reg_write(tmr_addr(3, `ADV_TIMER_OFS_COMPARE), 32'd100);
      reg_write(tmr_addr(3, `ADV_TIMER_OFS_CTRL), 32'h1);
      @(posedge hclk);                              // pwm is one cycle behind
      watch_pwm(3, 1'b1, 40);
      reg_write(tmr_addr(3, `ADV_TIMER_OFS_CTRL), 32'h0);

      repeat (2) @(posedge hclk);
      if (dut_i.chk_i.err_cnt == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         stop_on_failure("A concurrent assertion in the checker failed");
      end
   end

endmodule : apb_adv_timer_ss_tb

`default_nettype wire

//--- project.f
+incdir+hw
hw/adv_timer_pkg.sv
hw/apb_timer_regs.sv
hw/adv_timer_block.sv
hw/timer_event_irq.sv
hw/apb_adv_timer_ss.sv
test/tb_clk_gen.sv
test/apb_adv_timer_ss_chk.sv
test/apb_adv_timer_ss_tb.sv

//--- Makefile
# Verilator build and run of the APB timer subsystem testbench
TOP := apb_adv_timer_ss_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "FAIL: run ended early"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
